// File: include/cfg_regs_defines.svh
`ifndef CFG_REGS_DEFINES_SVH
`define CFG_REGS_DEFINES_SVH

// Host bus
`define CFG_DATA_W          32
`define CFG_ADDR_W          12
`define CFG_REGION_LSB      8           // Region field is address bits 11:8

// Region codes
`define CFG_REGION_CTRL     4'd0
`define CFG_REGION_CON      4'd1
`define CFG_REGION_WEI      4'd3

// Byte offsets inside the control region
`define CFG_WORD_CTRL       8'h00
`define CFG_WORD_GIE        8'h04
`define CFG_WORD_IE         8'h08
`define CFG_WORD_ISR        8'h0C
`define CFG_WORD_CYCLES     8'h14
`define CFG_WORD_STALLS     8'h18

`define CFG_REGION_WORDS    2           // Words per config region

// Control word bit positions
`define CFG_BIT_START       0
`define CFG_BIT_DONE        1
`define CFG_BIT_IDLE        2
`define CFG_BIT_READY       3
`define CFG_BIT_MEMSW       16
`define CFG_BIT_KEEP_A      17          // Keep B and C follow at 18 and 19
`define CFG_BIT_SOFTRST     23

`define CFG_SIGNATURE       8'hAC       // Top byte of the control word
`define CFG_BAD_ADDR        32'h2BADADD2

// Payload field sizes
`define CFG_IDX_W           15
`define CFG_TH_W            2
`define CFG_NCOLS           8
`define CFG_NBANKS          3           // Double-buffered SRAM banks A, B, C

`endif

// File: rtl/cfg_regs_pkg.sv
`include "cfg_regs_defines.svh"

package cfg_regs_pkg;

    // Working words of one region, word 0 in the low bits
    typedef logic [`CFG_REGION_WORDS-1:0][`CFG_DATA_W-1:0] region_words_t;

    // ******************************************************************
    // Control region payload (first field in bit 0)
    // ******************************************************************
    typedef struct packed {
        logic [`CFG_REGION_WORDS*`CFG_DATA_W-3*`CFG_IDX_W-`CFG_TH_W-3:0] spare;
        logic                       sram_powergate;     // Power gate for all SRAMs
        logic                       sram_deepsleep;     // Deep sleep for all SRAMs
        logic [`CFG_TH_W-1:0]       thres;              // Zero detection threshold
        logic [`CFG_IDX_W-1:0]      wei_reps;           // Weight data repetitions
        logic [`CFG_IDX_W-1:0]      act_reps;           // Activation data repetitions
        logic [`CFG_IDX_W-1:0]      incntlim;           // Input counter limit
    } con_cfg_t;

    // ******************************************************************
    // Weight region payload (first field in bit 0)
    // ******************************************************************
    typedef struct packed {
        logic [`CFG_REGION_WORDS*`CFG_DATA_W-3*`CFG_IDX_W-`CFG_NCOLS-2:0] spare;
        logic                       waligned;           // Weights aligned in memory
        logic [`CFG_NCOLS-1:0]      cols_active;        // One bit per array column
        logic [`CFG_IDX_W-1:0]      til_klim;           // Out-channel tiling limit
        logic [`CFG_IDX_W-1:0]      wstep;              // Weight counter step
        logic [`CFG_IDX_W-1:0]      wlim;               // Weight counter limit
    } wei_cfg_t;

endpackage

// File: rtl/cfg_host_port.sv
`timescale 1ns/100ps
`include "cfg_regs_defines.svh"

module cfg_host_port import cfg_regs_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic [`CFG_ADDR_W-1:0]      i_address,
    input  logic [`CFG_DATA_W-1:0]      i_data_in,
    input  logic [`CFG_DATA_W-1:0]      i_wmask,        // Per-bit write mask
    input  logic                        i_wren,
    input  logic                        i_rden,
    input  region_words_t               i_con_words,    // Working copies for readback
    input  region_words_t               i_wei_words,
    input  logic                        i_done_rise,
    input  logic                        i_ready,
    input  logic [`CFG_DATA_W-1:0]      i_cycle_cnt,
    input  logic [`CFG_DATA_W-1:0]      i_stall_cnt,
    output logic [`CFG_REGION_LSB-3:0]  o_word_idx,     // Address bits 7:2
    output logic [`CFG_DATA_W-1:0]      o_wdata,
    output logic [`CFG_DATA_W-1:0]      o_wmask,
    output logic                        o_con_we,
    output logic                        o_wei_we,
    output logic                        o_start_req,
    output logic                        o_memsw_req,
    output logic                        o_softrst_req,
    output logic [`CFG_NBANKS-1:0]      o_keep,         // Bit 0 is bank A
    output logic                        o_doneintr,
    output logic [`CFG_DATA_W-1:0]      o_data_out
);

    logic [`CFG_ADDR_W-`CFG_REGION_LSB-1:0] region;
    logic [`CFG_REGION_LSB-1:0]             offset;
    logic                                   in_range;   // Word index inside a config region
    logic [`CFG_DATA_W-1:0]                 wbits;      // Data bits with mask set
    logic                                   ctrl_we, gie_we, ie_we, isr_we;
    logic                                   done_q, gie_q, ie_q, isr_q;
    logic [`CFG_DATA_W-1:0]                 ctrl_word;
    logic [`CFG_DATA_W-1:0]                 rdata;

    // ******************************************************************
    // Address decode
    // ******************************************************************
    assign region     = i_address[`CFG_ADDR_W-1:`CFG_REGION_LSB];
    assign offset     = i_address[`CFG_REGION_LSB-1:0];
    assign o_word_idx = i_address[`CFG_REGION_LSB-1:2];
    assign in_range   = (o_word_idx < `CFG_REGION_WORDS);
    assign wbits      = i_data_in & i_wmask;

    assign ctrl_we = i_wren && (region == `CFG_REGION_CTRL) && (offset == `CFG_WORD_CTRL);
    assign gie_we  = i_wren && (region == `CFG_REGION_CTRL) && (offset == `CFG_WORD_GIE);
    assign ie_we   = i_wren && (region == `CFG_REGION_CTRL) && (offset == `CFG_WORD_IE);
    assign isr_we  = i_wren && (region == `CFG_REGION_CTRL) && (offset == `CFG_WORD_ISR);

    // Both banks see the same write bus, only the addressed one is enabled
    assign o_wdata  = i_data_in;
    assign o_wmask  = i_wmask;
    assign o_con_we = i_wren && (region == `CFG_REGION_CON) && in_range;
    assign o_wei_we = i_wren && (region == `CFG_REGION_WEI) && in_range;

    // ******************************************************************
    // Control and interrupt registers
    // ******************************************************************
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_start_req   <= 1'b0;
            o_memsw_req   <= 1'b0;
            o_softrst_req <= 1'b0;
            o_keep        <= '0;
            done_q        <= 1'b0;
            gie_q         <= 1'b0;
            ie_q          <= 1'b0;
            isr_q         <= 1'b0;
        end else begin
            // Pulse bits drop again on the next edge
            o_start_req   <= ctrl_we & wbits[`CFG_BIT_START];
            o_memsw_req   <= ctrl_we & wbits[`CFG_BIT_MEMSW];
            o_softrst_req <= ctrl_we & wbits[`CFG_BIT_SOFTRST];
            if (ctrl_we) begin
                o_keep <= (o_keep & ~i_wmask[`CFG_BIT_KEEP_A +: `CFG_NBANKS])
                        | wbits[`CFG_BIT_KEEP_A +: `CFG_NBANKS];
            end
            if (gie_we && i_wmask[0])
                gie_q <= i_data_in[0];
            if (ie_we && i_wmask[0])
                ie_q <= i_data_in[0];

            // Clear on write, a new done rise sets it again
            if (i_done_rise)
                done_q <= 1'b1;
            else if (ctrl_we && wbits[`CFG_BIT_DONE])
                done_q <= 1'b0;
            if (i_done_rise)
                isr_q <= 1'b1;
            else if (isr_we && wbits[0])
                isr_q <= 1'b0;
        end
    end

    assign o_doneintr = isr_q & gie_q & ie_q;

    // ******************************************************************
    // Read path
    // ******************************************************************
    always_comb begin
        ctrl_word                   = '0;
        ctrl_word[`CFG_BIT_START]   = o_start_req;
        ctrl_word[`CFG_BIT_DONE]    = done_q;
        ctrl_word[`CFG_BIT_IDLE]    = i_ready;          // Idle mirrors ready
        ctrl_word[`CFG_BIT_READY]   = i_ready;
        ctrl_word[`CFG_BIT_MEMSW]   = o_memsw_req;
        ctrl_word[`CFG_BIT_SOFTRST] = o_softrst_req;
        ctrl_word[`CFG_BIT_KEEP_A +: `CFG_NBANKS] = o_keep;
        ctrl_word[`CFG_DATA_W-1 -: 8]             = `CFG_SIGNATURE;
    end

    always_comb begin
        rdata = `CFG_BAD_ADDR;                          // Unmapped unless matched below
        case (region)
            `CFG_REGION_CTRL: begin
                case (offset)
                    `CFG_WORD_CTRL:   rdata = ctrl_word;
                    `CFG_WORD_GIE:    rdata = `CFG_DATA_W'(gie_q);
                    `CFG_WORD_IE:     rdata = `CFG_DATA_W'(ie_q);
                    `CFG_WORD_ISR:    rdata = `CFG_DATA_W'(isr_q);
                    `CFG_WORD_CYCLES: rdata = i_cycle_cnt;
                    `CFG_WORD_STALLS: rdata = i_stall_cnt;
                    default:          rdata = `CFG_BAD_ADDR;
                endcase
            end
            `CFG_REGION_CON: if (in_range) rdata = i_con_words[o_word_idx];
            `CFG_REGION_WEI: if (in_range) rdata = i_wei_words[o_word_idx];
            default:         rdata = `CFG_BAD_ADDR;
        endcase
    end

    // Read word is held while i_rden is low
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn)
            o_data_out <= '0;
        else if (i_rden)
            o_data_out <= rdata;
    end

endmodule

// File: rtl/cfg_shadow_bank.sv
`timescale 1ns/100ps
`include "cfg_regs_defines.svh"

module cfg_shadow_bank import cfg_regs_pkg::*; #(
    parameter type payload_t = region_words_t   // Struct view of the region
) (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_we,           // Region addressed and in range
    input  logic [`CFG_REGION_LSB-3:0]  i_word_idx,
    input  logic [`CFG_DATA_W-1:0]      i_wdata,
    input  logic [`CFG_DATA_W-1:0]      i_wmask,
    input  logic                        i_launch,       // Accepted start
    output region_words_t               o_words,        // Working copy
    output payload_t                    o_cfg           // Shadow copy
);

    localparam int SEL_W = $clog2(`CFG_REGION_WORDS);

    logic [SEL_W-1:0] sel;

    assign sel = i_word_idx[SEL_W-1:0];                 // Range already checked by host port

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_words <= '0;
            o_cfg   <= '0;
        end else begin
            // Only masked bits of the indexed word change
            if (i_we) begin
                o_words[sel] <= (o_words[sel] & ~i_wmask) | (i_wdata & i_wmask);
            end
            // Shadow takes the working copy as it stood before this edge
            if (i_launch) begin
                o_cfg <= payload_t'(o_words);
            end
        end
    end

endmodule

// File: rtl/run_sequencer.sv
`timescale 1ns/100ps
`include "cfg_regs_defines.svh"

module run_sequencer (
    input  logic                    i_clk,
    input  logic                    i_rstn,
    input  logic                    i_start_req,
    input  logic                    i_memsw_req,
    input  logic                    i_softrst_req,
    input  logic [`CFG_NBANKS-1:0]  i_keep,
    input  logic                    i_done,         // Accelerator done level
    input  logic                    i_pipeline_en,
    input  logic                    i_pop_en,
    output logic                    o_start,
    output logic                    o_launch,       // Shadow capture strobe
    output logic                    o_soft_reset,
    output logic                    o_done_rise,
    output logic                    o_ready,
    output logic [`CFG_NBANKS-1:0]  o_sram_select,
    output logic [`CFG_DATA_W-1:0]  o_cycle_cnt,
    output logic [`CFG_DATA_W-1:0]  o_stall_cnt
);

    logic                   start_prev, memsw_prev, softrst_prev;
    logic                   start_edge, memsw_edge, softrst_edge;
    logic                   done_rise_q;    // Counting stops one edge after this
    logic                   count_en;
    logic [`CFG_NBANKS-1:0] toggle;

    // Edge detection
    assign start_edge   = i_start_req & ~start_prev;
    assign memsw_edge   = i_memsw_req & ~memsw_prev;
    assign softrst_edge = i_softrst_req & ~softrst_prev;
    assign o_done_rise  = i_done & ~o_ready;

    assign o_launch = start_edge & o_ready;             // Start only taken when idle
    assign toggle   = {`CFG_NBANKS{o_launch | memsw_edge}} & ~i_keep;

    // ******************************************************************
    // Pulses, ready and SRAM selects
    // ******************************************************************
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            start_prev    <= 1'b0;
            memsw_prev    <= 1'b0;
            softrst_prev  <= 1'b0;
            o_start       <= 1'b0;
            o_soft_reset  <= 1'b0;
            o_ready       <= 1'b1;                      // Avoids a done rise out of reset
            done_rise_q   <= 1'b0;
            o_sram_select <= '0;
        end else begin
            start_prev    <= i_start_req;
            memsw_prev    <= i_memsw_req;
            softrst_prev  <= i_softrst_req;
            o_start       <= start_edge;                // One cycle wide
            o_soft_reset  <= softrst_edge;
            o_ready       <= i_done;
            done_rise_q   <= o_done_rise;
            o_sram_select <= o_sram_select ^ toggle;    // Kept banks never flip
        end
    end

    // ******************************************************************
    // Cycle and stall counters
    // ******************************************************************
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            count_en    <= 1'b0;
            o_cycle_cnt <= '0;
            o_stall_cnt <= '0;
        end else if (o_launch) begin
            count_en    <= 1'b1;
            o_cycle_cnt <= '0;
            o_stall_cnt <= '0;
        end else begin
            if (count_en) begin
                o_cycle_cnt <= o_cycle_cnt + 1'b1;
                if (!i_pipeline_en || !i_pop_en)        // Hard or soft stall
                    o_stall_cnt <= o_stall_cnt + 1'b1;
            end
            if (done_rise_q)
                count_en <= 1'b0;
        end
    end

endmodule

// File: rtl/cfg_regs_top.sv
`timescale 1ns/100ps
`include "cfg_regs_defines.svh"

module cfg_regs_top import cfg_regs_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rstn,
    // Host bus
    input  logic [`CFG_ADDR_W-1:0]  i_address,
    input  logic [`CFG_DATA_W-1:0]  i_data_in,
    input  logic [`CFG_DATA_W-1:0]  i_wmask,
    input  logic                    i_wren,
    input  logic                    i_rden,
    // Accelerator status
    input  logic                    i_done,
    input  logic                    i_pipeline_en,
    input  logic                    i_pop_en,
    // Run control
    output logic                    o_start,
    output logic                    o_soft_reset,
    output logic                    o_doneintr,
    output logic [`CFG_NBANKS-1:0]  o_sram_select,
    // Control region fields
    output logic [`CFG_IDX_W-1:0]   o_incntlim,
    output logic [`CFG_IDX_W-1:0]   o_act_reps,
    output logic [`CFG_IDX_W-1:0]   o_wei_reps,
    output logic [`CFG_TH_W-1:0]    o_thres,
    output logic                    o_sram_deepsleep,
    output logic                    o_sram_powergate,
    // Weight region fields
    output logic [`CFG_IDX_W-1:0]   o_wlim,
    output logic [`CFG_IDX_W-1:0]   o_wstep,
    output logic [`CFG_IDX_W-1:0]   o_til_klim,
    output logic [`CFG_NCOLS-1:0]   o_cols_active,
    output logic                    o_waligned,
    output logic [`CFG_DATA_W-1:0]  o_data_out
);

    logic [`CFG_REGION_LSB-3:0] word_idx;
    logic [`CFG_DATA_W-1:0]     wdata, wmask;
    logic                       con_we, wei_we;
    region_words_t              con_words, wei_words;
    con_cfg_t                   con_cfg;
    wei_cfg_t                   wei_cfg;
    logic                       start_req, memsw_req, softrst_req;
    logic [`CFG_NBANKS-1:0]     keep;
    logic                       launch, done_rise, ready;
    logic [`CFG_DATA_W-1:0]     cycle_cnt, stall_cnt;

    cfg_host_port u_host_port (
        .i_clk, .i_rstn, .i_address, .i_data_in, .i_wmask, .i_wren, .i_rden,
        .i_con_words(con_words), .i_wei_words(wei_words),
        .i_done_rise(done_rise), .i_ready(ready),
        .i_cycle_cnt(cycle_cnt), .i_stall_cnt(stall_cnt),
        .o_word_idx(word_idx), .o_wdata(wdata), .o_wmask(wmask),
        .o_con_we(con_we), .o_wei_we(wei_we),
        .o_start_req(start_req), .o_memsw_req(memsw_req), .o_softrst_req(softrst_req),
        .o_keep(keep), .o_doneintr, .o_data_out
    );

    cfg_shadow_bank #(.payload_t(con_cfg_t)) u_con_bank (
        .i_clk, .i_rstn, .i_we(con_we), .i_word_idx(word_idx),
        .i_wdata(wdata), .i_wmask(wmask), .i_launch(launch),
        .o_words(con_words), .o_cfg(con_cfg)
    );

    cfg_shadow_bank #(.payload_t(wei_cfg_t)) u_wei_bank (
        .i_clk, .i_rstn, .i_we(wei_we), .i_word_idx(word_idx),
        .i_wdata(wdata), .i_wmask(wmask), .i_launch(launch),
        .o_words(wei_words), .o_cfg(wei_cfg)
    );

    run_sequencer u_run_sequencer (
        .i_clk, .i_rstn, .i_start_req(start_req), .i_memsw_req(memsw_req),
        .i_softrst_req(softrst_req), .i_keep(keep), .i_done, .i_pipeline_en, .i_pop_en,
        .o_start, .o_launch(launch), .o_soft_reset, .o_done_rise(done_rise),
        .o_ready(ready), .o_sram_select, .o_cycle_cnt(cycle_cnt), .o_stall_cnt(stall_cnt)
    );

    // Shadow fields out to the accelerator
    assign o_incntlim       = con_cfg.incntlim;
    assign o_act_reps       = con_cfg.act_reps;
    assign o_wei_reps       = con_cfg.wei_reps;
    assign o_thres          = con_cfg.thres;
    assign o_sram_deepsleep = con_cfg.sram_deepsleep;
    assign o_sram_powergate = con_cfg.sram_powergate;
    assign o_wlim           = wei_cfg.wlim;
    assign o_wstep          = wei_cfg.wstep;
    assign o_til_klim       = wei_cfg.til_klim;
    assign o_cols_active    = wei_cfg.cols_active;
    assign o_waligned       = wei_cfg.waligned;

endmodule

// File: testbench/tb_cfg_regs.sv
`timescale 1ns/100ps
`include "cfg_regs_defines.svh"

module tb_cfg_regs;

    localparam int TIMEOUT_CYCLES = 2000;              // Tests need a few hundred cycles
    localparam logic [11:0] A_CTRL = 12'h000, A_GIE = 12'h004, A_IE = 12'h008;
    localparam logic [11:0] A_ISR = 12'h00C, A_CYC = 12'h014, A_STL = 12'h018;
    localparam logic [31:0] SIG = 32'hAC00_0000;       // Signature in the top byte

    logic        i_clk = 1'b0;
    logic        i_rstn, i_wren, i_rden, i_done, i_pipeline_en, i_pop_en;
    logic [11:0] i_address;
    logic [31:0] i_data_in, i_wmask, o_data_out;
    logic        o_start, o_soft_reset, o_doneintr, o_sram_deepsleep, o_sram_powergate;
    logic        o_waligned;
    logic [2:0]  o_sram_select;
    logic [14:0] o_incntlim, o_act_reps, o_wei_reps, o_wlim, o_wstep, o_til_klim;
    logic [1:0]  o_thres;
    logic [7:0]  o_cols_active;

    // Reference model
    logic [31:0] work_con [2];                         // Working words per region
    logic [31:0] work_wei [2];
    logic [63:0] shd_con, shd_wei;                     // Shadow copies
    logic [2:0]  exp_sel, keep;
    int          exp_cycles, exp_stalls;
    int          errors = 0, test_errs, n_pass = 0, n_fail = 0;
    int          cyc = 0, n_start = 0, n_softrst = 0;

    cfg_regs_top u_cfg_regs_top (.*);

    always #4 i_clk = ~i_clk;                          // 8 ns period

    // Pulse counters see the value from before the edge
    always @(posedge i_clk) begin
        if (o_start) n_start++;
        if (o_soft_reset) n_softrst++;
        cyc++;
        if (cyc == TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    start_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rstn) o_start |=> !o_start)
        else begin
            errors++;
            $display("o_start stayed high longer than one cycle at %0t", $time);
        end
    softrst_one_cycle: assert property
        (@(posedge i_clk) disable iff (!i_rstn) o_soft_reset |=> !o_soft_reset)
        else begin
            errors++;
            $display("o_soft_reset stayed high longer than one cycle at %0t", $time);
        end

    // ******************************************************************
    // Helpers
    // ******************************************************************
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge i_clk);
            #1;                                        // Drive just after the edge
        end
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [31:0] d, input logic [31:0] m);
        i_address = addr;
        i_data_in = d;
        i_wmask   = m;
        i_wren    = 1'b1;
        tick(1);
        i_wren    = 1'b0;
        i_wmask   = '0;
    endtask

    task automatic bus_read(input logic [11:0] addr, input logic [31:0] exp);
        i_address = addr;
        i_rden    = 1'b1;
        tick(1);                                       // Data registered at this edge
        i_rden    = 1'b0;
        check($sformatf("o_data_out @%h", addr), exp, o_data_out);
    endtask

    task automatic check_cfg();
        check("o_incntlim", shd_con[14:0], o_incntlim);
        check("o_act_reps", shd_con[29:15], o_act_reps);
        check("o_wei_reps", shd_con[44:30], o_wei_reps);
        check("o_thres", shd_con[46:45], o_thres);
        check("o_sram_deepsleep", shd_con[47], o_sram_deepsleep);
        check("o_sram_powergate", shd_con[48], o_sram_powergate);
        check("o_wlim", shd_wei[14:0], o_wlim);
        check("o_wstep", shd_wei[29:15], o_wstep);
        check("o_til_klim", shd_wei[44:30], o_til_klim);
        check("o_cols_active", shd_wei[52:45], o_cols_active);
        check("o_waligned", shd_wei[53], o_waligned);
    endtask

    // Random masked write to one region word and the matching model update
    task automatic region_write(input bit wei, input int w);
        logic [31:0] d, m;
        d = $urandom;
        m = $urandom;
        bus_write((wei ? 12'h300 : 12'h100) + 12'(w * 4), d, m);
        if (wei) work_wei[w] = (work_wei[w] & ~m) | (d & m);
        else     work_con[w] = (work_con[w] & ~m) | (d & m);
    endtask

    task automatic set_keep(input logic [2:0] k);
        bus_write(A_CTRL, 32'(k) << 17, 32'h7 << 17);
        keep = k;
    endtask

    // Writes start and checks the pulse and what a launch should have done
    task automatic start_run(input bit accepted);
        int n0;
        n0 = n_start;
        bus_write(A_CTRL, 32'h1, 32'h1);
        check("o_start", 0, o_start);
        tick(1);
        check("o_start", 1, o_start);
        if (accepted) begin
            shd_con = {work_con[1], work_con[0]};
            shd_wei = {work_wei[1], work_wei[0]};
            exp_sel ^= ~keep;                          // Unkept banks swap
        end
        check_cfg();
        check("o_sram_select", exp_sel, o_sram_select);
        tick(1);
        check("o_start", 0, o_start);
        check("o_start pulse count", n0 + 1, n_start);
    endtask

    task automatic mem_switch();
        bus_write(A_CTRL, 32'h1 << 16, 32'h1 << 16);
        check("o_sram_select", exp_sel, o_sram_select);
        tick(1);
        exp_sel ^= ~keep;
        check("o_sram_select", exp_sel, o_sram_select);
    endtask

    // Random stalls on every cycle and i_done rising after len cycles
    task automatic run_and_count(input int len);
        for (int i = 0; i < len + 2; i++) begin
            i_done = (i >= len);
            {i_pipeline_en, i_pop_en} = 2'($urandom);
            tick(1);
            exp_cycles++;                              // Last one is the edge after done
            if (!i_pipeline_en || !i_pop_en) exp_stalls++;
        end
        i_pipeline_en = 1'b1;
        i_pop_en      = 1'b1;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errs) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    // ******************************************************************
    // Tests
    // ******************************************************************
    initial begin
        void'($urandom(12922));
        i_rstn = 1'b0;
        i_address = '0;
        i_data_in = '0;
        i_wmask = '0;
        i_wren = 1'b0;
        i_rden = 1'b0;
        i_done = 1'b1;
        i_pipeline_en = 1'b1;
        i_pop_en = 1'b1;
        work_con = '{default: '0};
        work_wei = '{default: '0};
        shd_con = '0;
        shd_wei = '0;
        exp_sel = '0;
        keep = '0;
        test_errs = 0;
        repeat (10) @(posedge i_clk);
        #1;
        i_rstn = 1'b1;

        // 1. Reset state
        check("o_data_out", 0, o_data_out);
        bus_read(A_CTRL, SIG | 32'hC);                 // Idle and ready with done high
        bus_read(A_GIE, 0);
        bus_read(A_IE, 0);
        bus_read(A_ISR, 0);
        bus_read(A_CYC, 0);
        bus_read(A_STL, 0);
        check("o_sram_select", 0, o_sram_select);
        check("o_doneintr", 0, o_doneintr);
        check("o_start pulse count", 0, n_start);
        check("o_soft_reset pulse count", 0, n_softrst);
        check_cfg();
        end_test("reset_state");

        // 2. Masked writes and readback
        for (int p = 0; p < 3; p++)
            for (int r = 0; r < 2; r++)
                for (int w = 0; w < 2; w++) begin
                    region_write(r, w);
                    bus_read((r ? 12'h300 : 12'h100) + 12'(w * 4), r ? work_wei[w] : work_con[w]);
                end
        i_address = 12'h200;                           // Address moves on with i_rden low
        tick(2);
        check("o_data_out held", work_wei[1], o_data_out);
        bus_read(12'h108, `CFG_BAD_ADDR);              // Word index past the region
        bus_read(12'h30C, `CFG_BAD_ADDR);
        bus_read(12'h200, `CFG_BAD_ADDR);              // Unused region code
        bus_read(12'h010, `CFG_BAD_ADDR);              // Hole in the control region
        check_cfg();                                   // Shadows still at reset
        end_test("masked_writes");

        // 3. Start while ready, then while busy
        set_keep(3'($urandom));
        start_run(1'b1);
        i_done = 1'b0;
        tick(3);
        region_write(1'b0, 0);
        region_write(1'b1, 1);
        start_run(1'b0);                               // Not ready so nothing is captured
        end_test("start_launch");

        // 4. Done and interrupt
        bus_write(A_GIE, 1, 1);
        i_done = 1'b1;
        tick(1);                                       // Rising done sampled here
        bus_read(A_CTRL, SIG | (32'(keep) << 17) | 32'hE);
        bus_read(A_ISR, 1);
        check("o_doneintr", 0, o_doneintr);
        bus_write(A_IE, 1, 1);
        check("o_doneintr", 1, o_doneintr);
        bus_write(A_GIE, 0, 1);
        check("o_doneintr", 0, o_doneintr);
        bus_write(A_GIE, 1, 1);
        bus_write(A_CTRL, 0, 32'h2);                   // Writing 0 keeps done
        bus_write(A_ISR, 0, 1);
        bus_read(A_CTRL, SIG | (32'(keep) << 17) | 32'hE);
        check("o_doneintr", 1, o_doneintr);
        bus_write(A_CTRL, 32'h2, 32'h2);
        bus_write(A_ISR, 1, 1);
        check("o_doneintr", 0, o_doneintr);
        bus_read(A_CTRL, SIG | (32'(keep) << 17) | 32'hC);
        bus_read(A_ISR, 0);
        end_test("done_interrupt");

        // 5. Cycle and stall counters
        region_write(1'b0, 1);
        region_write(1'b1, 0);
        start_run(1'b1);
        exp_cycles = 1;                                // Edge after launch counts with both enables high
        exp_stalls = 0;
        run_and_count(5 + int'($urandom % 20));
        tick(3);
        bus_read(A_CYC, exp_cycles);
        bus_read(A_STL, exp_stalls);
        end_test("counters");

        // 6. Memory switch and soft reset
        set_keep(3'b101);
        mem_switch();                                  // Idle
        set_keep(3'($urandom));
        start_run(1'b1);
        i_done = 1'b0;
        tick(3);
        mem_switch();                                  // During a run
        i_done = 1'b1;
        tick(2);
        begin
            int n0;
            n0 = n_softrst;
            bus_write(A_CTRL, 32'h1 << 23, 32'h1 << 23);
            check("o_soft_reset", 0, o_soft_reset);
            tick(1);
            check("o_soft_reset", 1, o_soft_reset);
            tick(1);
            check("o_soft_reset", 0, o_soft_reset);
            check("o_soft_reset pulse count", n0 + 1, n_softrst);
        end
        check("o_sram_select", exp_sel, o_sram_select);
        end_test("memsw_softrst");

        $display("summary: %0d tests ok, %0d tests with errors", n_pass, n_fail);
        if (errors == 0 && n_fail == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: cfg_regs.f
+incdir+include
rtl/cfg_regs_pkg.sv
rtl/cfg_host_port.sv
rtl/cfg_shadow_bank.sv
rtl/run_sequencer.sv
rtl/cfg_regs_top.sv
testbench/tb_cfg_regs.sv

// File: Bender.yml
package:
  name: cfg_regs

export_include_dirs:
  - include

sources:
  - files:
      - rtl/cfg_regs_pkg.sv
      - rtl/cfg_host_port.sv
      - rtl/cfg_shadow_bank.sv
      - rtl/run_sequencer.sv
      - rtl/cfg_regs_top.sv
  - target: test
    files:
      - testbench/tb_cfg_regs.sv
